// ==== Makefile ====
SIM        := verilator
TOP        := tb_core
FILELIST   := rv_core.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
FAIL_MSG   := ** FAIL **
BIN        := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // ALU operation codes, one per supported instruction
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_ADDI,
    ALU_ANDI,
    ALU_ORI,
    ALU_XORI,
    ALU_SLTI,
    ALU_BEQ,
    ALU_BNE,
    ALU_NONE
  } alu_op_t;

  ////////////////////////////////////////
  // instruction views
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_insn_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_insn_t;

  // branch offset is scattered around the register fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_insn_t;

  typedef union packed {
    r_insn_t r;
    i_insn_t i;
    b_insn_t b;
  } insn_u;

  // opcodes and function fields
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // reset values
  localparam word_t DEFAULT_RESET_PC = 32'h0000_0000;
  localparam word_t PC_STEP          = 32'd4;
  // addi x0, x0, 0
  localparam word_t NOP_INSN         = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== common/id_ex_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded instruction handed from decode to execute
interface id_ex_if;
  import core_pkg::*;

  logic      valid;
  word_t     pc;
  alu_op_t   alu_op;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  reg_addr_t rd_addr;

  modport decode (
    output valid, pc, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd_addr
  );

  modport execute (
    input valid, pc, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd_addr
  );

endinterface

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter core_pkg::word_t RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            redirect_i,
  input  core_pkg::word_t redirect_pc_i,
  input  core_pkg::word_t imem_rdata_i,
  output core_pkg::word_t imem_addr_o,
  output logic            fetch_valid_o,
  output core_pkg::word_t fetch_pc_o,
  output core_pkg::insn_u fetch_insn_o
);
  import core_pkg::*;

  word_t pc_q;
  word_t issued_pc_q;
  logic  slot_valid_q;
  logic  kill_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q         <= RESET_PC;
      slot_valid_q <= 1'b0;
      kill_q       <= 1'b0;
    end else begin
      pc_q         <= redirect_i ? redirect_pc_i : pc_q + PC_STEP;
      slot_valid_q <= 1'b1;
      // word already requested behind the branch is dropped
      kill_q       <= redirect_i;
    end
  end

  // address of the word that arrives next cycle
  always_ff @(posedge clk_i) begin
    issued_pc_q <= pc_q;
  end

  assign imem_addr_o   = pc_q;
  assign fetch_valid_o = slot_valid_q & ~kill_q;
  assign fetch_pc_o    = issued_pc_q;
  assign fetch_insn_o  = fetch_valid_o ? imem_rdata_i : NOP_INSN;

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  input  logic                wb_en_i,
  input  core_pkg::reg_addr_t wb_addr_i,
  input  core_pkg::word_t     wb_data_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o
);
  import core_pkg::*;

  // x0 has no storage
  word_t regs_q [1:31];

  // same-cycle write is passed straight through
  function automatic word_t read_port(input reg_addr_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wb_en_i && (wb_addr_i == addr)) begin
      data = wb_data_i;
    end else begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_en_i && (wb_addr_i != '0)) begin
      regs_q[wb_addr_i] <= wb_data_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter core_pkg::word_t RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_pkg::word_t     imem_rdata_i,
  output core_pkg::word_t     imem_addr_o,
  output logic                retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::word_t     retire_next_pc_o,
  output core_pkg::reg_addr_t retire_rd_addr_o,
  output core_pkg::word_t     retire_rd_wdata_o
);
  import core_pkg::*;

  logic      fetch_valid;
  word_t     fetch_pc;
  insn_u     fetch_insn;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  logic      redirect;
  word_t     redirect_pc;

  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  id_ex_if u_id_ex ();

  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .imem_rdata_i (imem_rdata_i),
    .imem_addr_o  (imem_addr_o),
    .fetch_valid_o(fetch_valid),
    .fetch_pc_o   (fetch_pc),
    .fetch_insn_o (fetch_insn)
  );

  // register file sits beside decode (read) and execute (write)
  regfile u_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .wb_en_i   (wb_en),
    .wb_addr_i (wb_addr),
    .wb_data_i (wb_data),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  decode_stage u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fetch_valid_i(fetch_valid),
    .fetch_pc_i   (fetch_pc),
    .fetch_insn_i (fetch_insn),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .redirect_i   (redirect),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .id_ex        (u_id_ex.decode)
  );

  execute_stage u_execute (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .id_ex           (u_id_ex.execute),
    .redirect_o      (redirect),
    .redirect_pc_o   (redirect_pc),
    .wb_en_o         (wb_en),
    .wb_addr_o       (wb_addr),
    .wb_data_o       (wb_data),
    .retire_valid_o  (retire_valid_o),
    .retire_pc_o     (retire_pc_o),
    .retire_next_pc_o(retire_next_pc_o)
  );

  assign retire_rd_addr_o  = wb_addr;
  assign retire_rd_wdata_o = wb_data;

endmodule

`default_nettype wire

// ==== pipeline/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                fetch_valid_i,
  input  core_pkg::word_t     fetch_pc_i,
  input  core_pkg::insn_u     fetch_insn_i,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  input  logic                redirect_i,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  id_ex_if.decode             id_ex
);
  import core_pkg::*;

  alu_op_t   op_d;
  word_t     imm_d;
  reg_addr_t rs1_d;
  reg_addr_t rs2_d;
  reg_addr_t rd_d;

  ////////////////////////////////////////
  // decode by opcode
  ////////////////////////////////////////

  always_comb begin
    op_d  = ALU_NONE;
    imm_d = '0;
    rs1_d = '0;
    rs2_d = '0;
    rd_d  = '0;
    unique case (fetch_insn_i.r.opcode)
      OPC_OP: begin
        rs1_d = fetch_insn_i.r.rs1;
        rs2_d = fetch_insn_i.r.rs2;
        if (fetch_insn_i.r.funct7 == F7_BASE) begin
          unique case (fetch_insn_i.r.funct3)
            F3_ADD:  op_d = ALU_ADD;
            F3_SLT:  op_d = ALU_SLT;
            F3_XOR:  op_d = ALU_XOR;
            F3_OR:   op_d = ALU_OR;
            F3_AND:  op_d = ALU_AND;
            default: op_d = ALU_NONE;
          endcase
        end else if (fetch_insn_i.r.funct7 == F7_SUB && fetch_insn_i.r.funct3 == F3_ADD) begin
          op_d = ALU_SUB;
        end
        if (op_d != ALU_NONE) rd_d = fetch_insn_i.r.rd;
      end
      OPC_OP_IMM: begin
        rs1_d = fetch_insn_i.i.rs1;
        imm_d = {{(XLEN-12){fetch_insn_i.i.imm12[11]}}, fetch_insn_i.i.imm12};
        unique case (fetch_insn_i.i.funct3)
          F3_ADD:  op_d = ALU_ADDI;
          F3_SLT:  op_d = ALU_SLTI;
          F3_XOR:  op_d = ALU_XORI;
          F3_OR:   op_d = ALU_ORI;
          F3_AND:  op_d = ALU_ANDI;
          default: op_d = ALU_NONE;
        endcase
        if (op_d != ALU_NONE) rd_d = fetch_insn_i.i.rd;
      end
      OPC_BRANCH: begin
        rs1_d = fetch_insn_i.b.rs1;
        rs2_d = fetch_insn_i.b.rs2;
        imm_d = {{(XLEN-12){fetch_insn_i.b.imm12}}, fetch_insn_i.b.imm11,
                 fetch_insn_i.b.imm10_5, fetch_insn_i.b.imm4_1, 1'b0};
        if (fetch_insn_i.b.funct3 == F3_BEQ) op_d = ALU_BEQ;
        else if (fetch_insn_i.b.funct3 == F3_BNE) op_d = ALU_BNE;
      end
      default: ;
    endcase
  end

  assign rs1_addr_o = rs1_d;
  assign rs2_addr_o = rs2_d;

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) id_ex.valid <= 1'b0;
    // younger slot is flushed by a taken branch
    else id_ex.valid <= fetch_valid_i & ~redirect_i;
  end

  always_ff @(posedge clk_i) begin
    id_ex.pc       <= fetch_pc_i;
    id_ex.alu_op   <= op_d;
    id_ex.rs1_addr <= rs1_d;
    id_ex.rs2_addr <= rs2_d;
    id_ex.rs1_data <= rs1_data_i;
    id_ex.rs2_data <= rs2_data_i;
    id_ex.imm      <= imm_d;
    id_ex.rd_addr  <= rd_d;
  end

endmodule

`default_nettype wire

// ==== pipeline/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                clk_i,
  input  logic                rst_i,
  id_ex_if.execute            id_ex,
  output logic                redirect_o,
  output core_pkg::word_t     redirect_pc_o,
  output logic                wb_en_o,
  output core_pkg::reg_addr_t wb_addr_o,
  output core_pkg::word_t     wb_data_o,
  output logic                retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::word_t     retire_next_pc_o
);
  import core_pkg::*;

  word_t rs1_fwd;
  word_t rs2_fwd;
  word_t op_b;
  logic  use_imm;
  logic  taken;
  word_t result;
  word_t next_pc;

  ////////////////////////////////////////
  // forwarding from the retiring slot
  ////////////////////////////////////////

  // wb_en is only set for rd != 0
  assign rs1_fwd = (wb_en_o && wb_addr_o == id_ex.rs1_addr) ? wb_data_o : id_ex.rs1_data;
  assign rs2_fwd = (wb_en_o && wb_addr_o == id_ex.rs2_addr) ? wb_data_o : id_ex.rs2_data;

  assign use_imm = id_ex.alu_op inside {ALU_ADDI, ALU_ANDI, ALU_ORI, ALU_XORI, ALU_SLTI};
  assign op_b    = use_imm ? id_ex.imm : rs2_fwd;

  ////////////////////////////////////////
  // ALU and branch compare
  ////////////////////////////////////////

  always_comb begin
    result = '0;
    taken  = 1'b0;
    unique case (id_ex.alu_op)
      ALU_ADD, ALU_ADDI: result = rs1_fwd + op_b;
      ALU_SUB:           result = rs1_fwd - op_b;
      ALU_AND, ALU_ANDI: result = rs1_fwd & op_b;
      ALU_OR, ALU_ORI:   result = rs1_fwd | op_b;
      ALU_XOR, ALU_XORI: result = rs1_fwd ^ op_b;
      ALU_SLT, ALU_SLTI: begin
        result = {{(XLEN-1){1'b0}}, $signed(rs1_fwd) < $signed(op_b)};
      end
      ALU_BEQ: taken = (rs1_fwd == rs2_fwd);
      ALU_BNE: taken = (rs1_fwd != rs2_fwd);
      default: ;
    endcase
  end

  assign redirect_pc_o = id_ex.pc + id_ex.imm;
  assign redirect_o    = id_ex.valid & taken;
  assign next_pc       = taken ? redirect_pc_o : id_ex.pc + PC_STEP;

  ////////////////////////////////////////
  // retirement record
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_valid_o   <= 1'b0;
      wb_en_o          <= 1'b0;
      wb_addr_o        <= '0;
      wb_data_o        <= '0;
      retire_pc_o      <= '0;
      retire_next_pc_o <= '0;
    end else begin
      retire_valid_o   <= id_ex.valid;
      wb_en_o          <= id_ex.valid && (id_ex.rd_addr != '0);
      wb_addr_o        <= id_ex.rd_addr;
      // branches and no-ops come through with rd 0
      wb_data_o        <= (id_ex.rd_addr != '0) ? result : '0;
      retire_pc_o      <= id_ex.pc;
      retire_next_pc_o <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
common/core_pkg.sv
common/id_ex_if.sv
hw/fetch_unit.sv
hw/regfile.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
hw/rv_core_top.sv
testbench/core_assert.sv
testbench/tb_core.sv

// ==== testbench/core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_assert (
  input logic                clk_i,
  input logic                rst_i,
  input core_pkg::word_t     imem_addr_i,
  input logic                retire_valid_i,
  input core_pkg::word_t     retire_next_pc_i,
  input core_pkg::reg_addr_t retire_rd_addr_i,
  input core_pkg::word_t     retire_rd_wdata_i
);

  // strobe is cleared by the first reset edge
  a_no_retire_in_reset: assert property (
    @(posedge clk_i) rst_i && $past(rst_i) |-> !retire_valid_i
  ) else $error("retirement strobe while reset is held");

  a_rd0_no_data: assert property (
    @(posedge clk_i) disable iff (rst_i) retire_rd_addr_i == '0 |-> retire_rd_wdata_i == '0
  ) else $error("rd 0 retired with nonzero write data");

  a_fetch_aligned: assert property (
    @(posedge clk_i) disable iff (rst_i) imem_addr_i[1:0] == 2'b00
  ) else $error("instruction address not word aligned");

  a_next_pc_aligned: assert property (
    @(posedge clk_i) disable iff (rst_i) retire_valid_i |-> retire_next_pc_i[1:0] == 2'b00
  ) else $error("retired next pc not word aligned");

endmodule

bind rv_core_top core_assert u_core_assert (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .imem_addr_i      (imem_addr_o),
  .retire_valid_i   (retire_valid_o),
  .retire_next_pc_i (retire_next_pc_o),
  .retire_rd_addr_i (retire_rd_addr_o),
  .retire_rd_wdata_i(retire_rd_wdata_o)
);

`default_nettype wire

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;
  import core_pkg::*;

  localparam word_t TB_RESET_PC = 32'h0000_0000;
  // words of the four programs below, drives the watchdog limit
  localparam int PROG_WORDS  = 16 + 8 + 14 + 64;
  localparam int CYCLE_LIMIT = PROG_WORDS * 2 + 50;
  localparam int MEM_WORDS   = 256;

  typedef struct packed {
    word_t     pc;
    word_t     next_pc;
    reg_addr_t rd;
    word_t     data;
  } retire_rec_t;

  logic      clk_i = 1'b0;
  logic      rst_i = 1'b1;
  word_t     imem_rdata = NOP_INSN;
  word_t     imem_addr;
  logic      retire_valid;
  word_t     retire_pc;
  word_t     retire_next_pc;
  reg_addr_t retire_rd_addr;
  word_t     retire_rd_wdata;

  word_t       imem [MEM_WORDS];
  word_t       model_regs [32];
  retire_rec_t exp_q [$];
  word_t       prog [$];
  logic [31:0] lfsr_state = 32'h8fc6fb98;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  rv_core_top #(
    .RESET_PC(TB_RESET_PC)
  ) u_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .imem_rdata_i     (imem_rdata),
    .imem_addr_o      (imem_addr),
    .retire_valid_o   (retire_valid),
    .retire_pc_o      (retire_pc),
    .retire_next_pc_o (retire_next_pc),
    .retire_rd_addr_o (retire_rd_addr),
    .retire_rd_wdata_o(retire_rd_wdata)
  );

  always #50 clk_i = ~clk_i;

  // one-cycle synchronous instruction memory
  always @(posedge clk_i) begin
    imem_rdata <= imem[imem_addr[9:2]];
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d  checks: %0d", error_count, check_count);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////
  // compare helpers
  ////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %s: got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %s: got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("error: %s at %0t", what, $time);
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                  input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], OPC_OP_IMM};
  endfunction

  function automatic word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                  input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [2:0] f3_pick(input int n);
    case (n)
      0:       return F3_ADD;
      1:       return F3_SLT;
      2:       return F3_XOR;
      3:       return F3_OR;
      default: return F3_AND;
    endcase
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // one instruction in program order on the architectural registers
  function automatic retire_rec_t model_step(input word_t pc);
    retire_rec_t rec;
    word_t       insn;
    word_t       a;
    word_t       b;
    word_t       res;
    logic        wr;
    insn        = imem[pc[9:2]];
    a           = model_regs[insn[19:15]];
    b           = model_regs[insn[24:20]];
    res         = '0;
    wr          = 1'b1;
    rec.pc      = pc;
    rec.next_pc = pc + 32'd4;
    case (insn[6:0])
      OPC_OP, OPC_OP_IMM: begin
        if (insn[6:0] == OPC_OP_IMM) b = {{20{insn[31]}}, insn[31:20]};
        else if (insn[31:25] == F7_SUB && insn[14:12] == F3_ADD) b = -b;
        else if (insn[31:25] != F7_BASE) wr = 1'b0;
        case (insn[14:12])
          F3_ADD:  res = a + b;
          F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          F3_XOR:  res = a ^ b;
          F3_OR:   res = a | b;
          F3_AND:  res = a & b;
          default: wr = 1'b0;
        endcase
      end
      OPC_BRANCH: begin
        wr = 1'b0;
        if ((insn[14:12] == F3_BEQ && a == b) || (insn[14:12] == F3_BNE && a != b)) begin
          rec.next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      default: wr = 1'b0;
    endcase
    rec.rd   = (wr && insn[11:7] != '0) ? insn[11:7] : '0;
    rec.data = (rec.rd != '0) ? res : '0;
    if (rec.rd != '0) model_regs[rec.rd] = rec.data;
    return rec;
  endfunction

  task automatic reset_dut();
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_word("imem_addr_o", imem_addr, TB_RESET_PC);
    if (retire_valid) note_failure("retirement strobe right after reset");
  endtask

  task automatic run_program(input string name);
    word_t       pc;
    retire_rec_t rec;
    int          seen;
    seen = 0;
    for (int k = 0; k < MEM_WORDS; k++) imem[k] = NOP_INSN;
    for (int k = 0; k < prog.size(); k++) imem[k] = prog[k];
    for (int k = 0; k < 32; k++) model_regs[k] = '0;
    pc = TB_RESET_PC;
    while (pc < word_t'(prog.size() * 4)) begin
      rec = model_step(pc);
      exp_q.push_back(rec);
      pc = rec.next_pc;
    end
    reset_dut();
    while (exp_q.size() > 0) begin
      @(negedge clk_i);
      if (retire_valid) begin
        rec = exp_q.pop_front();
        seen++;
        check_word("retire_pc_o", retire_pc, rec.pc);
        check_word("retire_next_pc_o", retire_next_pc, rec.next_pc);
        check_reg_addr("retire_rd_addr_o", retire_rd_addr, rec.rd);
        check_word("retire_rd_wdata_o", retire_rd_wdata, rec.data);
      end
    end
    $display("%s: %0d retirements checked", name, seen);
    prog.delete();
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_alu();
    prog.push_back(enc_i(F3_ADD, 1, 0, -5));
    prog.push_back(enc_i(F3_ADD, 2, 0, 7));
    prog.push_back(enc_i(F3_OR, 3, 0, 'h0f0));
    prog.push_back(enc_i(F3_XOR, 4, 0, 'h7ff));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 5, 1, 2));
    prog.push_back(enc_r(F7_SUB, F3_ADD, 6, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_AND, 7, 3, 4));
    prog.push_back(enc_r(F7_BASE, F3_OR, 8, 1, 3));
    prog.push_back(enc_r(F7_BASE, F3_XOR, 9, 2, 4));
    prog.push_back(enc_r(F7_BASE, F3_SLT, 10, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_SLT, 11, 2, 1));
    prog.push_back(enc_i(F3_AND, 12, 1, 'h0ff));
    prog.push_back(enc_i(F3_SLT, 13, 2, -1));
    prog.push_back(enc_i(F3_SLT, 14, 1, -3));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 0, 1, 2));
    // slli lies outside the subset and retires as a no-op
    prog.push_back(enc_i(3'b001, 15, 1, 1));
    run_program("alu");
  endtask

  task automatic test_dependencies();
    prog.push_back(enc_i(F3_ADD, 1, 0, 3));
    prog.push_back(enc_i(F3_ADD, 1, 1, 4));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 2, 1, 1));
    prog.push_back(enc_i(F3_ADD, 3, 0, -2));
    prog.push_back(enc_r(F7_SUB, F3_ADD, 4, 2, 3));
    prog.push_back(enc_r(F7_BASE, F3_XOR, 5, 4, 3));
    prog.push_back(enc_r(F7_BASE, F3_SLT, 6, 5, 4));
    prog.push_back(enc_r(F7_BASE, F3_OR, 7, 6, 5));
    run_program("dependencies");
  endtask

  task automatic test_branches();
    prog.push_back(enc_i(F3_ADD, 1, 0, 5));
    prog.push_back(enc_i(F3_ADD, 2, 0, 5));
    prog.push_back(enc_b(F3_BEQ, 1, 2, 12));
    prog.push_back(enc_i(F3_ADD, 3, 0, 1));
    prog.push_back(enc_i(F3_ADD, 4, 0, 1));
    prog.push_back(enc_b(F3_BNE, 1, 2, 8));
    prog.push_back(enc_i(F3_ADD, 5, 0, 9));
    prog.push_back(enc_b(F3_BNE, 5, 1, 12));
    prog.push_back(enc_i(F3_ADD, 6, 0, 1));
    prog.push_back(enc_i(F3_ADD, 7, 0, 1));
    prog.push_back(enc_b(F3_BEQ, 5, 0, 8));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 8, 3, 5));
    // jumps just past the end of the program
    prog.push_back(enc_b(F3_BEQ, 0, 0, 8));
    prog.push_back(enc_i(F3_ADD, 9, 0, 1));
    run_program("branches");
  endtask

  task automatic test_random();
    int is_imm;
    int rd;
    int rs1;
    int rs2;
    int sel;
    int imm;
    for (int n = 0; n < 64; n++) begin
      is_imm = rand_bits(1);
      rd     = rand_bits(3);
      rs1    = rand_bits(3);
      rs2    = rand_bits(3);
      sel    = rand_bits(3);
      imm    = rand_bits(12);
      if (is_imm == 1) prog.push_back(enc_i(f3_pick(sel % 5), rd, rs1, imm));
      else if (sel % 6 == 5) prog.push_back(enc_r(F7_SUB, F3_ADD, rd, rs1, rs2));
      else prog.push_back(enc_r(F7_BASE, f3_pick(sel % 6), rd, rs1, rs2));
    end
    run_program("random");
  endtask

  initial begin
    test_alu();
    test_dependencies();
    test_branches();
    test_random();
    $display("errors: %0d  checks: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
